/* hdl/rv_isa_pkg.sv */
/*
  RISC-V base encodings for the RV32I and RV64I integer subsets only.
  Float, atomic, vector and CSR encodings are not described here.
*/
package rv_isa_pkg;

    typedef logic [31:0] instr_t;   // one uncompressed instruction word
    typedef logic [6:0]  opcode_t;  // major opcode, bits [6:0]
    typedef logic [2:0]  funct3_t;  // bits [14:12]
    typedef logic [6:0]  funct7_t;  // bits [31:25]
    typedef logic [4:0]  reg_idx_t; // integer register index
    typedef logic [31:0] imm_t;     // immediate after sign or zero extension

    // every major opcode ends in 2'b11, so compressed words never match one
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_imm_w  = 7'b0011011; // rv64 only
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_reg_w  = 7'b0111011; // rv64 only
    localparam opcode_t op_fence  = 7'b0001111;
    localparam opcode_t op_system = 7'b1110011;

    localparam funct3_t f3_jalr    = 3'b000;

    localparam funct3_t f3_beq     = 3'b000;
    localparam funct3_t f3_bne     = 3'b001;
    localparam funct3_t f3_blt     = 3'b100;
    localparam funct3_t f3_bge     = 3'b101;
    localparam funct3_t f3_bltu    = 3'b110;
    localparam funct3_t f3_bgeu    = 3'b111;

    // access width for loads and stores
    localparam funct3_t f3_byte    = 3'b000;
    localparam funct3_t f3_half    = 3'b001;
    localparam funct3_t f3_word    = 3'b010;
    localparam funct3_t f3_dword   = 3'b011;  // rv64 only
    localparam funct3_t f3_byte_u  = 3'b100;
    localparam funct3_t f3_half_u  = 3'b101;
    localparam funct3_t f3_word_u  = 3'b110;  // rv64 only

    // integer alu ops, shared by the immediate and register forms
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    localparam funct3_t f3_fence   = 3'b000;
    localparam funct3_t f3_fence_i = 3'b001;
    localparam funct3_t f3_priv    = 3'b000;  // ecall and ebreak

    localparam funct7_t f7_base    = 7'b0000000;
    localparam funct7_t f7_alt     = 7'b0100000;  // sub and arithmetic right shift

endpackage

/* hdl/rv_decode_pkg.sv */
/*
  Decoder output encodings. Unit and function codes are local to this core
  and follow no external standard.
*/
package rv_decode_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        unit_adder   = 4'h1,
        unit_logic   = 4'h2,
        unit_memory  = 4'h3,
        unit_shift   = 4'h4,
        unit_branch  = 4'h5,
        unit_sync    = 4'h6,
        unit_system  = 4'h7,
        unit_illegal = 4'hf
    } unit_e;

    // one code per supported instruction, grouped by opcode
    typedef enum logic [7:0] {
        fn_lui = 8'h00, fn_auipc, fn_jal, fn_jalr,
        fn_beq, fn_bne, fn_blt, fn_bge, fn_bltu, fn_bgeu,
        fn_lb, fn_lh, fn_lw, fn_lbu, fn_lhu, fn_lwu, fn_ld,
        fn_sb, fn_sh, fn_sw, fn_sd,
        fn_addi, fn_slti, fn_sltiu, fn_xori, fn_ori, fn_andi,
        fn_slli, fn_srli, fn_srai,
        fn_add, fn_sub, fn_sll, fn_slt, fn_sltu, fn_xor, fn_srl, fn_sra, fn_or, fn_and,
        fn_addiw, fn_slliw, fn_srliw, fn_sraiw,
        fn_addw, fn_subw, fn_sllw, fn_srlw, fn_sraw,
        fn_fence, fn_fence_i, fn_ecall, fn_ebreak,
        fn_illegal = 8'hff
    } func_e;

    typedef enum logic [2:0] {
        fmt_r, fmt_i, fmt_sh, fmt_s, fmt_b, fmt_u, fmt_j, fmt_none
    } fmt_e;

    typedef struct packed {
        unit_e    unit;
        func_e    func;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
    } dec_instr_t;

    localparam dec_instr_t dec_illegal = '{
        unit: unit_illegal, func: fn_illegal, rd: '0, rs1: '0, rs2: '0, imm: '0
    };

endpackage

/* hdl/rv_op_classifier.sv */
/*
  Purely combinational. Any encoding outside the supported integer set gives
  fn_illegal and legal low, and unit and fmt then carry no meaning.
*/
`timescale 1ns/100ps

module rv_op_classifier
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
#(
    parameter bit rv64_en = 1'b1
) (
    input  instr_t instr,
    output unit_e  unit,
    output func_e  func,
    output fmt_e   fmt,
    output logic   legal
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    shamt_ok;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // bit 25 is shamt[5] for the immediate shifts and needs 64-bit registers
    assign shamt_ok = rv64_en || !instr[25];

    always_comb begin
        func = fn_illegal;  // unmatched combinations fall through as illegal
        case (opcode)
            op_lui:   func = fn_lui;
            op_auipc: func = fn_auipc;
            op_jal:   func = fn_jal;
            op_jalr: begin
                if (funct3 == f3_jalr) func = fn_jalr;
            end
            op_branch: begin
                case (funct3)
                    f3_beq:  func = fn_beq;
                    f3_bne:  func = fn_bne;
                    f3_blt:  func = fn_blt;
                    f3_bge:  func = fn_bge;
                    f3_bltu: func = fn_bltu;
                    f3_bgeu: func = fn_bgeu;
                    default: ;
                endcase
            end
            op_load: begin
                case (funct3)
                    f3_byte:   func = fn_lb;
                    f3_half:   func = fn_lh;
                    f3_word:   func = fn_lw;
                    f3_byte_u: func = fn_lbu;
                    f3_half_u: func = fn_lhu;
                    f3_word_u: func = rv64_en ? fn_lwu : fn_illegal;
                    f3_dword:  func = rv64_en ? fn_ld : fn_illegal;
                    default: ;
                endcase
            end
            op_store: begin
                case (funct3)
                    f3_byte:  func = fn_sb;
                    f3_half:  func = fn_sh;
                    f3_word:  func = fn_sw;
                    f3_dword: func = rv64_en ? fn_sd : fn_illegal;
                    default: ;
                endcase
            end
            op_imm: begin
                case (funct3)
                    f3_add_sub: func = fn_addi;
                    f3_slt:     func = fn_slti;
                    f3_sltu:    func = fn_sltiu;
                    f3_xor:     func = fn_xori;
                    f3_or:      func = fn_ori;
                    f3_and:     func = fn_andi;
                    f3_sll: begin
                        if (funct7[6:1] == f7_base[6:1] && shamt_ok) func = fn_slli;
                    end
                    f3_srl_sra: begin
                        if (funct7[6:1] == f7_base[6:1] && shamt_ok) func = fn_srli;
                        else if (funct7[6:1] == f7_alt[6:1] && shamt_ok) func = fn_srai;
                    end
                endcase
            end
            op_imm_w: begin
                if (rv64_en) begin
                    case (funct3)
                        f3_add_sub: func = fn_addiw;
                        f3_sll: begin
                            if (funct7 == f7_base) func = fn_slliw;
                        end
                        f3_srl_sra: begin
                            if (funct7 == f7_base) func = fn_srliw;
                            else if (funct7 == f7_alt) func = fn_sraiw;
                        end
                        default: ;
                    endcase
                end
            end
            op_reg: begin
                if (funct7 == f7_base) begin
                    case (funct3)
                        f3_add_sub: func = fn_add;
                        f3_sll:     func = fn_sll;
                        f3_slt:     func = fn_slt;
                        f3_sltu:    func = fn_sltu;
                        f3_xor:     func = fn_xor;
                        f3_srl_sra: func = fn_srl;
                        f3_or:      func = fn_or;
                        f3_and:     func = fn_and;
                    endcase
                end else if (funct7 == f7_alt) begin
                    if (funct3 == f3_add_sub) func = fn_sub;
                    else if (funct3 == f3_srl_sra) func = fn_sra;
                end
            end
            op_reg_w: begin
                if (rv64_en && funct7 == f7_base) begin
                    if (funct3 == f3_add_sub) func = fn_addw;
                    else if (funct3 == f3_sll) func = fn_sllw;
                    else if (funct3 == f3_srl_sra) func = fn_srlw;
                end else if (rv64_en && funct7 == f7_alt) begin
                    if (funct3 == f3_add_sub) func = fn_subw;
                    else if (funct3 == f3_srl_sra) func = fn_sraw;
                end
            end
            op_fence: begin
                if (funct3 == f3_fence) func = fn_fence;
                else if (funct3 == f3_fence_i) func = fn_fence_i;
            end
            op_system: begin
                // only the two exact words, imm 0 or 1 with rd and rs1 at zero
                if (funct3 == f3_priv && instr[31:21] == 11'b0 && instr[19:15] == 5'b0 &&
                    instr[11:7] == 5'b0) begin
                    func = instr[20] ? fn_ebreak : fn_ecall;
                end
            end
            default: ;
        endcase
    end

    // execution unit and operand format follow from the function alone
    always_comb begin
        case (func)
            fn_lui:                                 {unit, fmt} = {unit_memory, fmt_u};
            fn_auipc:                               {unit, fmt} = {unit_adder, fmt_u};
            fn_jal:                                 {unit, fmt} = {unit_branch, fmt_j};
            fn_jalr:                                {unit, fmt} = {unit_branch, fmt_i};
            fn_beq, fn_bne, fn_blt, fn_bge, fn_bltu, fn_bgeu:
                                                    {unit, fmt} = {unit_branch, fmt_b};
            fn_lb, fn_lh, fn_lw, fn_lbu, fn_lhu, fn_lwu, fn_ld:
                                                    {unit, fmt} = {unit_memory, fmt_i};
            fn_sb, fn_sh, fn_sw, fn_sd:             {unit, fmt} = {unit_memory, fmt_s};
            fn_addi, fn_addiw:                      {unit, fmt} = {unit_adder, fmt_i};
            fn_slti, fn_sltiu, fn_xori, fn_ori, fn_andi:
                                                    {unit, fmt} = {unit_logic, fmt_i};
            fn_slli, fn_srli, fn_srai, fn_slliw, fn_srliw, fn_sraiw:
                                                    {unit, fmt} = {unit_shift, fmt_sh};
            fn_add, fn_sub, fn_addw, fn_subw:       {unit, fmt} = {unit_adder, fmt_r};
            fn_slt, fn_sltu, fn_xor, fn_or, fn_and: {unit, fmt} = {unit_logic, fmt_r};
            fn_sll, fn_srl, fn_sra, fn_sllw, fn_srlw, fn_sraw:
                                                    {unit, fmt} = {unit_shift, fmt_r};
            fn_fence, fn_fence_i:                   {unit, fmt} = {unit_sync, fmt_none};
            fn_ecall, fn_ebreak:                    {unit, fmt} = {unit_system, fmt_none};
            default:                                {unit, fmt} = {unit_illegal, fmt_none};
        endcase
    end

    assign legal = (func != fn_illegal);

endmodule

/* hdl/rv_operand_extract.sv */
/*
  Combinational operand extraction. Indices that the format does not use are
  zero, and shift amounts come out zero-extended in the immediate.
*/
`timescale 1ns/100ps

module rv_operand_extract
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
(
    input  instr_t   instr,
    input  fmt_e     fmt,
    output reg_idx_t rd,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output imm_t     imm
);

    // stores and branches write no register
    assign rd  = (fmt inside {fmt_s, fmt_b, fmt_none}) ? 5'b0 : instr[11:7];
    assign rs1 = (fmt inside {fmt_u, fmt_j, fmt_none}) ? 5'b0 : instr[19:15];
    assign rs2 = (fmt inside {fmt_r, fmt_s, fmt_b}) ? instr[24:20] : 5'b0;

    always_comb begin
        case (fmt)
            fmt_i: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            fmt_s: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            fmt_b: begin
                // branch offsets are in halfwords so bit 0 is always zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            fmt_u: begin
                imm = {instr[31:12], 12'b0};
            end
            fmt_j: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            fmt_sh: begin
                imm = {26'b0, instr[25:20]};  // bit 25 is zero for the 32-bit forms
            end
            default: begin
                imm = '0;  // r format and instructions without operands
            end
        endcase
    end

endmodule

/* hdl/rv_decode_stage.sv */
/*
  Single register slice with one cycle latency. in_ready depends on out_ready
  combinationally, so a long chain of these stages builds a long ready path.
*/
`timescale 1ns/100ps

module rv_decode_stage
    import rv_decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  dec_instr_t d,
    input  logic       in_valid,
    output logic       in_ready,
    output dec_instr_t dec,
    output logic       out_valid,
    input  logic       out_ready
);

    // the slot is free when empty or when its content leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;  // refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec <= d;  // held while stalled
        end
    end

endmodule

/* hdl/rv_decoder.sv */
/*
  Registered decoder for RV32I or RV64I integer words, without the C extension.
  Illegal words still flow through the stage and come out as dec_illegal.
*/
`timescale 1ns/100ps

module rv_decoder
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
#(
    parameter bit rv64_en = 1'b1
) (
    input  logic       clk,
    input  logic       rst,
    input  instr_t     instr,
    input  logic       in_valid,
    output logic       in_ready,
    output dec_instr_t dec,
    output logic       out_valid,
    input  logic       out_ready
);

    unit_e      cls_unit;
    func_e      cls_func;
    fmt_e       cls_fmt;
    logic       cls_legal;
    reg_idx_t   ex_rd;
    reg_idx_t   ex_rs1;
    reg_idx_t   ex_rs2;
    imm_t       ex_imm;
    dec_instr_t dec_d;

    rv_op_classifier #(
        .rv64_en (rv64_en)
    ) rv_op_classifier_inst (
        .instr (instr),
        .unit  (cls_unit),
        .func  (cls_func),
        .fmt   (cls_fmt),
        .legal (cls_legal)
    );

    rv_operand_extract rv_operand_extract_inst (
        .instr (instr),
        .fmt   (cls_fmt),
        .rd    (ex_rd),
        .rs1   (ex_rs1),
        .rs2   (ex_rs2),
        .imm   (ex_imm)
    );

    // an illegal word carries no operands downstream
    assign dec_d = cls_legal ? '{unit: cls_unit, func: cls_func, rd: ex_rd, rs1: ex_rs1,
                                 rs2: ex_rs2, imm: ex_imm} : dec_illegal;

    rv_decode_stage rv_decode_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .d         (dec_d),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .dec       (dec),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* bench/rv_decoder_checker.sv */
/*
  Watches both streams of rv_decoder. Expected values are queued on input
  transfers and compared in order on output transfers.
*/
`timescale 1ns/100ps

module rv_decoder_checker
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  instr_t     instr,
    input  logic       in_valid,
    input  logic       in_ready,
    input  dec_instr_t exp_d,
    input  dec_instr_t dec,
    input  logic       out_valid,
    input  logic       out_ready,
    output int         checked,
    output int         failed,
    output int         errors,
    output int         pending
);

    dec_instr_t exp_q[$];
    instr_t     word_q[$];   // words kept only for the report lines
    dec_instr_t held;        // dec at the previous edge
    logic       stalled;
    logic       seen_input;
    logic       took_word;   // a word was accepted at the previous edge

    function automatic bit field_ok(input string name, input logic [31:0] expv,
                                    input logic [31:0] actv);
        if (expv !== actv) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expv, actv);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    always @(posedge clk) begin
        dec_instr_t e;
        instr_t     w;
        bit         ok;
        logic       exp_ready;
        if (rst) begin
            exp_q.delete();
            word_q.delete();
            checked = 0;
            failed = 0;
            errors = 0;
            stalled = 1'b0;
            seen_input = 1'b0;
            took_word = 1'b0;
        end else begin
            if (out_valid !== 1'b0 && !seen_input) begin
                $display("out_valid was not low before the first word was accepted");
                errors++;
            end
            // one cycle of latency, so last edge's word must be on the output now
            if (took_word && out_valid !== 1'b1) begin
                $display("a word accepted at the previous edge did not reach the output");
                errors++;
            end
            if (stalled && (!out_valid || dec !== held)) begin
                $display("output changed while out_ready was low");
                errors++;
            end
            // back-pressure blocks the input, every other cycle takes a word
            exp_ready = (out_valid && !out_ready) ? 1'b0 : 1'b1;
            if (in_ready !== exp_ready) begin
                $display("CHECK FAILED in_ready expected %h actual %h", exp_ready, in_ready);
                errors++;
            end
            // pop before push, a word accepted at this edge is not out yet
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output transfer with no accepted word waiting for it");
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    w = word_q.pop_front();
                    ok = 1'b1;
                    ok = field_ok("dec.unit", 32'(e.unit), 32'(dec.unit)) & ok;
                    ok = field_ok("dec.func", 32'(e.func), 32'(dec.func)) & ok;
                    ok = field_ok("dec.rd", 32'(e.rd), 32'(dec.rd)) & ok;
                    ok = field_ok("dec.rs1", 32'(e.rs1), 32'(dec.rs1)) & ok;
                    ok = field_ok("dec.rs2", 32'(e.rs2), 32'(dec.rs2)) & ok;
                    ok = field_ok("dec.imm", e.imm, dec.imm) & ok;
                    checked++;
                    if (ok) begin
                        $display("test %0d instr %h ok", checked, w);
                    end else begin
                        failed++;
                        $display("test %0d instr %h wrong", checked, w);
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(exp_d);
                word_q.push_back(instr);
                seen_input = 1'b1;
            end
            took_word = in_valid && in_ready;
            stalled = out_valid && !out_ready;
            held = dec;
        end
        pending = exp_q.size();
    end

endmodule

/* bench/rv_decoder_tb.sv */
/*
  DUT runs with rv64_en set, so RV64 words are expected to decode.
  out_ready is random, in_valid stays high while table entries remain.
*/
`timescale 1ns/100ps

module rv_decoder_tb
    import rv_isa_pkg::*;
    import rv_decode_pkg::*;
();

    typedef struct packed {
        instr_t     word;
        dec_instr_t exp;
    } vec_t;

    logic       clk;
    logic       rst;
    instr_t     instr;
    logic       in_valid;
    logic       in_ready;
    dec_instr_t dec;
    logic       out_valid;
    logic       out_ready;
    dec_instr_t exp_d;      // expected result of the word on instr
    int         checked;
    int         failed;
    int         errors;
    int         pending;
    integer     seed;
    vec_t       vectors[$];

    rv_decoder #(
        .rv64_en (1'b1)
    ) rv_decoder_inst (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .dec       (dec),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    rv_decoder_checker rv_decoder_checker_inst (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .exp_d     (exp_d),
        .dec       (dec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .checked   (checked),
        .failed    (failed),
        .errors    (errors),
        .pending   (pending)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        #2;
        out_ready = ($random(seed) % 2) != 0;  // about half the cycles stall
    end

    task automatic add_vec(input instr_t w, input unit_e u, input func_e f, input int rd,
                           input int rs1, input int rs2, input int unsigned imm);
        vec_t v;
        v.word = w;
        v.exp.unit = u;
        v.exp.func = f;
        v.exp.rd = reg_idx_t'(rd);
        v.exp.rs1 = reg_idx_t'(rs1);
        v.exp.rs2 = reg_idx_t'(rs2);
        v.exp.imm = imm;
        vectors.push_back(v);
    endtask

    task automatic build_table();
        add_vec({20'h80001, 5'd5, op_lui}, unit_memory, fn_lui, 5, 0, 0, 'h80001000);
        add_vec({20'hfffff, 5'd31, op_auipc}, unit_adder, fn_auipc, 31, 0, 0, 'hfffff000);
        add_vec({1'b1, 10'h3fe, 1'b1, 8'hff, 5'd1, op_jal},
                unit_branch, fn_jal, 1, 0, 0, 'hfffffffc);
        add_vec({1'b0, 10'h155, 1'b1, 8'h5a, 5'd0, op_jal},
                unit_branch, fn_jal, 0, 0, 0, 'h0005aaaa);
        add_vec({12'hffc, 5'd1, 3'b000, 5'd5, op_jalr}, unit_branch, fn_jalr, 5, 1, 0, 'hfffffffc);
        // branch rd bits hold offset bits and must come out as zero
        add_vec({7'h7f, 5'd2, 5'd1, 3'b000, 5'h19, op_branch},
                unit_branch, fn_beq, 0, 1, 2, 'hfffffff8);
        add_vec({7'h00, 5'd4, 5'd3, 3'b001, 5'h10, op_branch}, unit_branch, fn_bne, 0, 3, 4, 'h10);
        add_vec({7'h00, 5'd2, 5'd1, 3'b100, 5'h01, op_branch}, unit_branch, fn_blt, 0, 1, 2, 'h800);
        add_vec({7'h00, 5'd2, 5'd1, 3'b101, 5'h04, op_branch}, unit_branch, fn_bge, 0, 1, 2, 'h4);
        add_vec({7'h3f, 5'd2, 5'd1, 3'b110, 5'h00, op_branch},
                unit_branch, fn_bltu, 0, 1, 2, 'h7e0);
        add_vec({7'h40, 5'd2, 5'd1, 3'b111, 5'h00, op_branch},
                unit_branch, fn_bgeu, 0, 1, 2, 'hfffff000);
        add_vec({12'h7ff, 5'd6, 3'b000, 5'd7, op_load}, unit_memory, fn_lb, 7, 6, 0, 'h7ff);
        add_vec({12'h800, 5'd6, 3'b001, 5'd7, op_load}, unit_memory, fn_lh, 7, 6, 0, 'hfffff800);
        add_vec({12'h000, 5'd6, 3'b010, 5'd7, op_load}, unit_memory, fn_lw, 7, 6, 0, 'h0);
        add_vec({12'hfff, 5'd6, 3'b100, 5'd7, op_load}, unit_memory, fn_lbu, 7, 6, 0, 'hffffffff);
        add_vec({12'h004, 5'd6, 3'b101, 5'd7, op_load}, unit_memory, fn_lhu, 7, 6, 0, 'h4);
        add_vec({12'h808, 5'd6, 3'b110, 5'd7, op_load}, unit_memory, fn_lwu, 7, 6, 0, 'hfffff808);
        add_vec({12'h010, 5'd6, 3'b011, 5'd7, op_load}, unit_memory, fn_ld, 7, 6, 0, 'h10);
        add_vec({7'h7f, 5'd9, 5'd8, 3'b000, 5'h1f, op_store},
                unit_memory, fn_sb, 0, 8, 9, 'hffffffff);
        add_vec({7'h00, 5'd9, 5'd8, 3'b001, 5'h05, op_store}, unit_memory, fn_sh, 0, 8, 9, 'h5);
        add_vec({7'h40, 5'd9, 5'd8, 3'b010, 5'h00, op_store},
                unit_memory, fn_sw, 0, 8, 9, 'hfffff800);
        add_vec({7'h01, 5'd9, 5'd8, 3'b011, 5'h00, op_store}, unit_memory, fn_sd, 0, 8, 9, 'h20);
        add_vec({12'hfff, 5'd2, 3'b000, 5'd1, op_imm}, unit_adder, fn_addi, 1, 2, 0, 'hffffffff);
        add_vec({12'h800, 5'd2, 3'b010, 5'd1, op_imm}, unit_logic, fn_slti, 1, 2, 0, 'hfffff800);
        add_vec({12'hfff, 5'd2, 3'b011, 5'd1, op_imm}, unit_logic, fn_sltiu, 1, 2, 0, 'hffffffff);
        add_vec({12'h555, 5'd2, 3'b100, 5'd1, op_imm}, unit_logic, fn_xori, 1, 2, 0, 'h555);
        add_vec({12'h0f0, 5'd2, 3'b110, 5'd1, op_imm}, unit_logic, fn_ori, 1, 2, 0, 'hf0);
        add_vec({12'hf00, 5'd2, 3'b111, 5'd1, op_imm}, unit_logic, fn_andi, 1, 2, 0, 'hffffff00);
        add_vec({6'h00, 6'h3f, 5'd2, 3'b001, 5'd1, op_imm}, unit_shift, fn_slli, 1, 2, 0, 'h3f);
        add_vec({6'h00, 6'h05, 5'd2, 3'b101, 5'd1, op_imm}, unit_shift, fn_srli, 1, 2, 0, 'h5);
        add_vec({6'h10, 6'h21, 5'd2, 3'b101, 5'd1, op_imm}, unit_shift, fn_srai, 1, 2, 0, 'h21);
        add_vec({7'h00, 5'd3, 5'd2, 3'b000, 5'd1, op_reg}, unit_adder, fn_add, 1, 2, 3, 0);
        add_vec({7'h20, 5'd3, 5'd2, 3'b000, 5'd1, op_reg}, unit_adder, fn_sub, 1, 2, 3, 0);
        add_vec({7'h00, 5'd3, 5'd2, 3'b001, 5'd1, op_reg}, unit_shift, fn_sll, 1, 2, 3, 0);
        add_vec({7'h00, 5'd3, 5'd2, 3'b010, 5'd1, op_reg}, unit_logic, fn_slt, 1, 2, 3, 0);
        add_vec({7'h00, 5'd3, 5'd2, 3'b011, 5'd1, op_reg}, unit_logic, fn_sltu, 1, 2, 3, 0);
        add_vec({7'h00, 5'd3, 5'd2, 3'b100, 5'd1, op_reg}, unit_logic, fn_xor, 1, 2, 3, 0);
        add_vec({7'h00, 5'd3, 5'd2, 3'b101, 5'd1, op_reg}, unit_shift, fn_srl, 1, 2, 3, 0);
        add_vec({7'h20, 5'd3, 5'd2, 3'b101, 5'd1, op_reg}, unit_shift, fn_sra, 1, 2, 3, 0);
        add_vec({7'h00, 5'd3, 5'd2, 3'b110, 5'd1, op_reg}, unit_logic, fn_or, 1, 2, 3, 0);
        add_vec({7'h00, 5'd3, 5'd2, 3'b111, 5'd1, op_reg}, unit_logic, fn_and, 1, 2, 3, 0);
        add_vec({12'h800, 5'd4, 3'b000, 5'd5, op_imm_w}, unit_adder, fn_addiw, 5, 4, 0, 'hfffff800);
        add_vec({7'h00, 5'd31, 5'd4, 3'b001, 5'd5, op_imm_w}, unit_shift, fn_slliw, 5, 4, 0, 'h1f);
        add_vec({7'h00, 5'd1, 5'd4, 3'b101, 5'd5, op_imm_w}, unit_shift, fn_srliw, 5, 4, 0, 'h1);
        add_vec({7'h20, 5'd17, 5'd4, 3'b101, 5'd5, op_imm_w}, unit_shift, fn_sraiw, 5, 4, 0, 'h11);
        add_vec({7'h00, 5'd6, 5'd4, 3'b000, 5'd5, op_reg_w}, unit_adder, fn_addw, 5, 4, 6, 0);
        add_vec({7'h20, 5'd6, 5'd4, 3'b000, 5'd5, op_reg_w}, unit_adder, fn_subw, 5, 4, 6, 0);
        add_vec({7'h00, 5'd6, 5'd4, 3'b001, 5'd5, op_reg_w}, unit_shift, fn_sllw, 5, 4, 6, 0);
        add_vec({7'h00, 5'd6, 5'd4, 3'b101, 5'd5, op_reg_w}, unit_shift, fn_srlw, 5, 4, 6, 0);
        add_vec({7'h20, 5'd6, 5'd4, 3'b101, 5'd5, op_reg_w}, unit_shift, fn_sraw, 5, 4, 6, 0);
        add_vec({4'h0, 4'hf, 4'hf, 5'd0, 3'b000, 5'd0, op_fence}, unit_sync, fn_fence, 0, 0, 0, 0);
        add_vec({12'h000, 5'd0, 3'b001, 5'd0, op_fence}, unit_sync, fn_fence_i, 0, 0, 0, 0);
        add_vec({12'h000, 5'd0, 3'b000, 5'd0, op_system}, unit_system, fn_ecall, 0, 0, 0, 0);
        add_vec({12'h001, 5'd0, 3'b000, 5'd0, op_system}, unit_system, fn_ebreak, 0, 0, 0, 0);
        // compressed, unknown opcode, bad funct7 and other system words
        add_vec(32'h00004501, unit_illegal, fn_illegal, 0, 0, 0, 0);
        add_vec({25'h0, 7'b1010111}, unit_illegal, fn_illegal, 0, 0, 0, 0);
        add_vec({7'h01, 5'd3, 5'd2, 3'b000, 5'd1, op_reg}, unit_illegal, fn_illegal, 0, 0, 0, 0);
        add_vec({6'h20, 6'h01, 5'd2, 3'b101, 5'd1, op_imm}, unit_illegal, fn_illegal, 0, 0, 0, 0);
        add_vec({7'h01, 5'd1, 5'd4, 3'b001, 5'd5, op_imm_w}, unit_illegal, fn_illegal, 0, 0, 0, 0);
        add_vec({12'h300, 5'd1, 3'b001, 5'd2, op_system}, unit_illegal, fn_illegal, 0, 0, 0, 0);
        add_vec({12'h000, 5'd0, 3'b000, 5'd1, op_system}, unit_illegal, fn_illegal, 0, 0, 0, 0);
    endtask

    // allows 20 cycles per table entry before giving up
    initial begin
        @(negedge rst);
        repeat (vectors.size() * 20) @(posedge clk);
        $display("watchdog expired before all words came out of the decoder");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        instr = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        exp_d = dec_illegal;
        seed = 32'h3d609224;
        build_table();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (vectors[i]) begin
            instr = vectors[i].word;
            exp_d = vectors[i].exp;
            in_valid = 1'b1;
            do @(posedge clk); while (!in_ready);  // leaves on the accepting edge
            #2;
        end
        in_valid = 1'b0;
        instr = '0;
        wait (checked == vectors.size());
        repeat (2) @(posedge clk);
        if (pending != 0) begin
            $display("%0d accepted words never came out of the decoder", pending);
        end
        $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                 checked, checked - failed, failed, errors);
        if (failed == 0 && errors == 0 && pending == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* rv_decoder.f */
hdl/rv_isa_pkg.sv
hdl/rv_decode_pkg.sv
hdl/rv_op_classifier.sv
hdl/rv_operand_extract.sv
hdl/rv_decode_stage.sv
hdl/rv_decoder.sv
bench/rv_decoder_checker.sv
bench/rv_decoder_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decoder testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module rv_decoder_tb \
    -f rv_decoder.f \
    -o rv_decoder_sim

./obj_dir/rv_decoder_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
